// File: rob_commit.f
rtl/rob_pkg.sv
rtl/rob_ctrl.sv
rtl/rob_queue.sv
rtl/retire_rat.sv
rtl/rob_top.sv
verification/rob_tb.sv

// File: verification/rob_tests.mem
// 01 dispatch: accept op0 rd0 pr0 op1 rd1 pr1 id0 id1 00 00 | 02 writeback: mask id0 id1
// 03 commit: op0 rd0 pr0 op1 rd1 pr1 order fv0 fp0 fv1 fp1 | 04 quiet: cycles | 00 end
01 01 00 01 14 01 02 15 00 01 00 00
01 01 00 03 16 02 05 17 02 03 00 00
01 01 00 04 18 03 00 19 04 05 00 00
01 01 00 00 1a 01 06 1b 06 07 00 00
01 00 00 07 1c 00 08 1d 00 00 00 00
02 03 00 01 00 00 00 00 00 00 00 00
03 00 01 14 01 02 15 00 01 01 01 02
01 01 00 07 1c 00 08 1d 00 01 00 00
02 03 04 05 00 00 00 00 00 00 00 00
04 04 00 00 00 00 00 00 00 00 00 00
02 03 02 03 00 00 00 00 00 00 00 00
03 00 03 16 02 05 17 02 01 03 00 00
03 00 04 18 03 00 19 04 01 04 00 00
02 01 06 00 00 00 00 00 00 00 00 00
04 02 00 00 00 00 00 00 00 00 00 00
02 02 00 07 00 00 00 00 00 00 00 00
03 00 00 1a 01 06 1b 06 00 00 01 06
02 03 00 01 00 00 00 00 00 00 00 00
03 00 07 1c 00 08 1d 08 01 07 01 08
01 01 00 01 1e 01 01 1f 02 03 00 00
02 03 03 02 00 00 00 00 00 00 00 00
03 00 01 1e 01 01 1f 0a 01 14 01 1e
01 01 02 02 20 00 02 21 04 05 00 00
01 01 00 03 22 00 04 23 06 07 00 00
02 03 06 07 00 00 00 00 00 00 00 00
04 02 00 00 00 00 00 00 00 00 00 00
02 03 04 05 00 00 00 00 00 00 00 00
03 02 02 20 00 02 21 0c 00 00 01 15
03 00 03 22 00 04 23 0e 01 16 01 18
01 01 01 01 24 00 05 25 00 01 00 00
02 03 00 01 00 00 00 00 00 00 00 00
03 01 01 24 00 05 25 10 01 1f 01 05
02 01 02 00 00 00 00 00 00 00 00 00
01 01 00 09 26 00 0a 27 02 03 00 00
02 02 00 03 00 00 00 00 00 00 00 00
04 02 00 00 00 00 00 00 00 00 00 00
02 01 02 00 00 00 00 00 00 00 00 00
03 00 09 26 00 0a 27 12 01 09 01 0a
00 00 00 00 00 00 00 00 00 00 00 00

// File: verification/rob_tb.sv
`default_nettype none

module rob_tb
    import rob_pkg::*;
();

    localparam int SS = 2;
    localparam int ROB_DEPTH = 8;
    localparam int PHYS_REGS = 64;
    localparam int ID_W = $clog2(ROB_DEPTH);
    localparam int PHYS_W = $clog2(PHYS_REGS);
    localparam int PERIOD = 40;
    // each record is 12 hex fields
    localparam int REC_W = 12;
    localparam int MAX_REC = 64;
    localparam int COMMIT_LIMIT = 20;
    localparam int CYCLES_PER_REC = 25;

    logic                       clk;
    logic                       rst;
    logic                       disp_valid;
    op_class_t [SS-1:0]         disp_op;
    logic [SS-1:0][ARCH_W-1:0]  disp_arch_rd;
    logic [SS-1:0][PHYS_W-1:0]  disp_phys_rd;
    logic                       disp_ready;
    logic [SS-1:0][ID_W-1:0]    disp_rob_id;
    logic [SS-1:0]              wb_valid;
    logic [SS-1:0][ID_W-1:0]    wb_rob_id;
    logic                       commit_valid;
    op_class_t [SS-1:0]         commit_op;
    logic [SS-1:0][ARCH_W-1:0]  commit_arch_rd;
    logic [SS-1:0][PHYS_W-1:0]  commit_phys_rd;
    logic [SS-1:0][63:0]        commit_order;
    logic [SS-1:0]              freed_valid;
    logic [SS-1:0][PHYS_W-1:0]  freed_phys;

    logic [7:0] test_mem [REC_W*MAX_REC];
    logic [7:0] rec [REC_W];
    int         n_rec;
    int         n_run;
    int         n_failed;
    int         test_err;
    logic       loaded;
    string      tname;

    rob_top #(
        .SS        (SS),
        .ROB_DEPTH (ROB_DEPTH),
        .PHYS_REGS (PHYS_REGS)
    ) UUT (
        .clk            (clk),
        .rst            (rst),
        .disp_valid     (disp_valid),
        .disp_op        (disp_op),
        .disp_arch_rd   (disp_arch_rd),
        .disp_phys_rd   (disp_phys_rd),
        .disp_ready     (disp_ready),
        .disp_rob_id    (disp_rob_id),
        .wb_valid       (wb_valid),
        .wb_rob_id      (wb_rob_id),
        .commit_valid   (commit_valid),
        .commit_op      (commit_op),
        .commit_arch_rd (commit_arch_rd),
        .commit_phys_rd (commit_phys_rd),
        .commit_order   (commit_order),
        .freed_valid    (freed_valid),
        .freed_phys     (freed_phys)
    );

    initial clk = 1'b0;
    always #(PERIOD/2) clk = ~clk;

    // scaled to the number of records in the data file
    initial begin
        wait (loaded === 1'b1);
        repeat (n_rec * CYCLES_PER_REC) @(posedge clk);
        $display("watchdog expired after %0d cycles, the test sequence did not finish",
                 n_rec * CYCLES_PER_REC);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s %s: expected %0h, actual %0h", tname, what, expected, actual);
            test_err++;
        end
    endtask

    // outputs depend only on registered state, so they are checked at the falling edge
    task automatic run_dispatch();
        disp_valid = 1'b1;
        for (int i = 0; i < SS; i++) begin
            disp_op[i] = op_class_t'(rec[2 + 3*i][1:0]);
            disp_arch_rd[i] = rec[3 + 3*i][ARCH_W-1:0];
            disp_phys_rd[i] = rec[4 + 3*i][PHYS_W-1:0];
        end
        check_value("disp_ready", rec[1][0], disp_ready);
        if (rec[1][0]) begin
            for (int i = 0; i < SS; i++) begin
                check_value($sformatf("disp_rob_id[%0d]", i), rec[8 + i][ID_W-1:0],
                            disp_rob_id[i]);
            end
        end
        @(negedge clk);
        disp_valid = 1'b0;
    endtask

    task automatic run_writeback();
        for (int i = 0; i < SS; i++) begin
            wb_valid[i] = rec[1][i];
            wb_rob_id[i] = rec[2 + i][ID_W-1:0];
        end
        @(negedge clk);
        wb_valid = '0;
    endtask

    task automatic run_wait_commit();
        int waited;
        waited = 0;
        while (commit_valid !== 1'b1 && waited < COMMIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (commit_valid === 1'b1) else begin
            $display("%s: no commit came within %0d cycles", tname, COMMIT_LIMIT);
            test_err++;
        end
        if (commit_valid === 1'b1) begin
            for (int i = 0; i < SS; i++) begin
                check_value($sformatf("commit_op[%0d]", i), rec[1 + 3*i][1:0], commit_op[i]);
                check_value($sformatf("commit_arch_rd[%0d]", i), rec[2 + 3*i],
                            commit_arch_rd[i]);
                check_value($sformatf("commit_phys_rd[%0d]", i), rec[3 + 3*i],
                            commit_phys_rd[i]);
                // slot i retires as order number base plus i
                check_value($sformatf("commit_order[%0d]", i), 64'(rec[7]) + 64'(i),
                            commit_order[i]);
                check_value($sformatf("freed_valid[%0d]", i), rec[8 + 2*i][0], freed_valid[i]);
                if (rec[8 + 2*i][0]) begin
                    check_value($sformatf("freed_phys[%0d]", i), rec[9 + 2*i], freed_phys[i]);
                end
            end
            @(negedge clk);
        end
    endtask

    task automatic run_quiet();
        for (int c = 0; c < rec[1]; c++) begin
            assert (commit_valid === 1'b0) else begin
                $display("%s: a commit happened in quiet cycle %0d", tname, c);
                test_err++;
            end
            @(negedge clk);
        end
    endtask

    initial begin
        rst = 1'b1;
        loaded = 1'b0;
        disp_valid = 1'b0;
        disp_arch_rd = '0;
        disp_phys_rd = '0;
        wb_valid = '0;
        wb_rob_id = '0;
        for (int i = 0; i < SS; i++) begin
            disp_op[i] = op_alu;
        end
        n_rec = 0;
        n_run = 0;
        n_failed = 0;
        for (int a = 0; a < REC_W*MAX_REC; a++) begin
            test_mem[a] = 8'h00;
        end
        $readmemh("verification/rob_tests.mem", test_mem);
        // a zero command ends the list
        while (n_rec < MAX_REC && test_mem[n_rec*REC_W] != 8'h00) begin
            n_rec++;
        end
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int t = 0; t < n_rec; t++) begin
            for (int k = 0; k < REC_W; k++) begin
                rec[k] = test_mem[t*REC_W + k];
            end
            test_err = 0;
            case (rec[0])
                8'h01: begin
                    tname = $sformatf("t%02d_%s", t, rec[1][0] ? "dispatch" : "dispatch_stall");
                    run_dispatch();
                end
                8'h02: begin
                    tname = $sformatf("t%02d_writeback", t);
                    run_writeback();
                end
                8'h03: begin
                    tname = $sformatf("t%02d_commit", t);
                    run_wait_commit();
                end
                8'h04: begin
                    tname = $sformatf("t%02d_quiet", t);
                    run_quiet();
                end
                default: begin
                    tname = $sformatf("t%02d_unknown", t);
                    $display("%s: unknown command %0h in the data file", tname, rec[0]);
                    test_err++;
                end
            endcase
            n_run++;
            if (test_err == 0) begin
                $display("%s: ok", tname);
            end else begin
                $display("%s: %0d check(s) failed", tname, test_err);
                n_failed++;
            end
        end

        if (n_rec == 0) begin
            $display("no test records were read from verification/rob_tests.mem");
            n_failed++;
        end
        $display("tests run: %0d, passed: %0d, failed: %0d", n_run, n_run - n_failed, n_failed);
        if (n_failed == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/rob_top.sv
`default_nettype none

module rob_top
    import rob_pkg::*;
#(
    parameter int SS = 2,
    parameter int ROB_DEPTH = 8,
    parameter int PHYS_REGS = 64,
    localparam int ID_W = $clog2(ROB_DEPTH),
    localparam int PHYS_W = $clog2(PHYS_REGS)
) (
    input  wire logic                       clk,
    input  wire logic                       rst,

    // dispatch
    input  wire logic                       disp_valid,
    input  op_class_t [SS-1:0]              disp_op,
    input  wire logic [SS-1:0][ARCH_W-1:0]  disp_arch_rd,
    input  wire logic [SS-1:0][PHYS_W-1:0]  disp_phys_rd,
    output logic                            disp_ready,
    output logic [SS-1:0][ID_W-1:0]         disp_rob_id,

    // writeback
    input  wire logic [SS-1:0]              wb_valid,
    input  wire logic [SS-1:0][ID_W-1:0]    wb_rob_id,

    // commit
    output logic                            commit_valid,
    output op_class_t [SS-1:0]              commit_op,
    output logic [SS-1:0][ARCH_W-1:0]       commit_arch_rd,
    output logic [SS-1:0][PHYS_W-1:0]       commit_phys_rd,
    output logic [SS-1:0][63:0]             commit_order,
    output logic [SS-1:0]                   freed_valid,
    output logic [SS-1:0][PHYS_W-1:0]       freed_phys
);

    logic                    push;
    logic                    retire;
    logic [ID_W-1:0]         head;
    logic [ID_W-1:0]         tail;
    logic [SS-1:0]           wb_mark;
    logic [SS-1:0][ID_W-1:0] wb_mark_id;
    logic [SS-1:0]           head_done;

    rob_ctrl #(
        .SS        (SS),
        .ROB_DEPTH (ROB_DEPTH)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .disp_valid   (disp_valid),
        .disp_ready   (disp_ready),
        .push         (push),
        .disp_rob_id  (disp_rob_id),
        .tail         (tail),
        .wb_valid     (wb_valid),
        .wb_rob_id    (wb_rob_id),
        .wb_mark      (wb_mark),
        .wb_mark_id   (wb_mark_id),
        .head_done    (head_done),
        .retire       (retire),
        .head         (head),
        .commit_order (commit_order),
        .commit_valid (commit_valid)
    );

    // head entries double as the commit outputs
    rob_queue #(
        .SS        (SS),
        .ROB_DEPTH (ROB_DEPTH),
        .PHYS_REGS (PHYS_REGS)
    ) u_queue (
        .clk          (clk),
        .rst          (rst),
        .push         (push),
        .tail         (tail),
        .disp_op      (disp_op),
        .disp_arch_rd (disp_arch_rd),
        .disp_phys_rd (disp_phys_rd),
        .wb_mark      (wb_mark),
        .wb_mark_id   (wb_mark_id),
        .retire       (retire),
        .head         (head),
        .head_done    (head_done),
        .head_op      (commit_op),
        .head_arch_rd (commit_arch_rd),
        .head_phys_rd (commit_phys_rd)
    );

    retire_rat #(
        .SS        (SS),
        .PHYS_REGS (PHYS_REGS)
    ) u_rat (
        .clk            (clk),
        .rst            (rst),
        .retire         (retire),
        .commit_op      (commit_op),
        .commit_arch_rd (commit_arch_rd),
        .commit_phys_rd (commit_phys_rd),
        .freed_valid    (freed_valid),
        .freed_phys     (freed_phys)
    );

endmodule

`default_nettype wire

// File: rtl/retire_rat.sv
`default_nettype none

module retire_rat
    import rob_pkg::*;
#(
    parameter int SS = 2,
    parameter int PHYS_REGS = 64,
    localparam int PHYS_W = $clog2(PHYS_REGS)
) (
    input  wire logic                       clk,
    input  wire logic                       rst,

    // retiring group, slot 0 oldest
    input  wire logic                       retire,
    input  op_class_t [SS-1:0]              commit_op,
    input  wire logic [SS-1:0][ARCH_W-1:0]  commit_arch_rd,
    input  wire logic [SS-1:0][PHYS_W-1:0]  commit_phys_rd,

    // displaced mappings, to go back to the free list
    output logic [SS-1:0]                   freed_valid,
    output logic [SS-1:0][PHYS_W-1:0]       freed_phys
);

    // committed architectural to physical map
    logic [PHYS_W-1:0] map [ARCH_REGS];

    logic [SS-1:0]     slot_wr;

    // x0 is never remapped
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            slot_wr[i] = retire && op_writes_rd(commit_op[i]) && (commit_arch_rd[i] != '0);
        end
    end

    // previous mapping per slot
    // an earlier slot of the same group writing the same register overrides the map
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            freed_phys[i] = map[commit_arch_rd[i]];
            for (int j = 0; j < i; j++) begin
                if (slot_wr[j] && (commit_arch_rd[j] == commit_arch_rd[i])) begin
                    freed_phys[i] = commit_phys_rd[j];
                end
            end
        end
    end

    assign freed_valid = slot_wr;

    // slot order matters, the youngest write to a register lands last
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                map[r] <= PHYS_W'(r);
            end
        end else begin
            for (int i = 0; i < SS; i++) begin
                if (slot_wr[i]) begin
                    map[commit_arch_rd[i]] <= commit_phys_rd[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/rob_queue.sv
`default_nettype none

module rob_queue
    import rob_pkg::*;
#(
    parameter int SS = 2,
    parameter int ROB_DEPTH = 8,
    parameter int PHYS_REGS = 64,
    localparam int ID_W = $clog2(ROB_DEPTH),
    localparam int PHYS_W = $clog2(PHYS_REGS)
) (
    input  wire logic                          clk,
    input  wire logic                          rst,

    // dispatch group, written at tail
    input  wire logic                          push,
    input  wire logic [ID_W-1:0]               tail,
    input  op_class_t [SS-1:0]                 disp_op,
    input  wire logic [SS-1:0][ARCH_W-1:0]     disp_arch_rd,
    input  wire logic [SS-1:0][PHYS_W-1:0]     disp_phys_rd,

    // completion marks, already filtered against occupancy
    input  wire logic [SS-1:0]                 wb_mark,
    input  wire logic [SS-1:0][ID_W-1:0]       wb_mark_id,

    // head group retirement
    input  wire logic                          retire,
    input  wire logic [ID_W-1:0]               head,

    output logic [SS-1:0]                      head_done,
    output op_class_t [SS-1:0]                 head_op,
    output logic [SS-1:0][ARCH_W-1:0]          head_arch_rd,
    output logic [SS-1:0][PHYS_W-1:0]          head_phys_rd
);

    // entry payload
    op_class_t            ent_op   [ROB_DEPTH];
    logic [ARCH_W-1:0]    ent_arch [ROB_DEPTH];
    logic [PHYS_W-1:0]    ent_phys [ROB_DEPTH];

    // one completion flag per entry
    logic [ROB_DEPTH-1:0] done;

    // per-slot positions relative to head and tail, wrapping on ID_W bits
    logic [SS-1:0][ID_W-1:0] head_idx;
    logic [SS-1:0][ID_W-1:0] tail_idx;

    genvar g;
    generate
        for (g = 0; g < SS; g++) begin : g_slot
            assign head_idx[g] = head + ID_W'(g);
            assign tail_idx[g] = tail + ID_W'(g);

            // combinational read of the oldest group
            assign head_done[g]    = done[head_idx[g]];
            assign head_op[g]      = ent_op[head_idx[g]];
            assign head_arch_rd[g] = ent_arch[head_idx[g]];
            assign head_phys_rd[g] = ent_phys[head_idx[g]];
        end
    endgenerate

    // payload write, the whole group lands at once
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < SS; i++) begin
                ent_op[tail_idx[i]]   <= disp_op[i];
                ent_arch[tail_idx[i]] <= disp_arch_rd[i];
                ent_phys[tail_idx[i]] <= disp_phys_rd[i];
            end
        end
    end

    // done flags
    // head and tail groups never overlap while both push and retire are live,
    // and marks only hit occupied entries, so the write order below is safe
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= '0;
        end else begin
            if (retire) begin
                for (int i = 0; i < SS; i++) begin
                    done[head_idx[i]] <= 1'b0;
                end
            end
            for (int i = 0; i < SS; i++) begin
                if (wb_mark[i]) begin
                    done[wb_mark_id[i]] <= 1'b1;
                end
            end
            // fresh entries start incomplete
            if (push) begin
                for (int i = 0; i < SS; i++) begin
                    done[tail_idx[i]] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/rob_ctrl.sv
`default_nettype none

module rob_ctrl #(
    parameter int SS = 2,
    parameter int ROB_DEPTH = 8,
    localparam int ID_W = $clog2(ROB_DEPTH),
    localparam int CNT_W = ID_W + 1
) (
    input  wire logic                     clk,
    input  wire logic                     rst,

    // dispatch handshake
    input  wire logic                     disp_valid,
    output logic                          disp_ready,
    output logic                          push,
    output logic [SS-1:0][ID_W-1:0]       disp_rob_id,
    output logic [ID_W-1:0]               tail,

    // writeback from the functional units
    input  wire logic [SS-1:0]            wb_valid,
    input  wire logic [SS-1:0][ID_W-1:0]  wb_rob_id,
    output logic [SS-1:0]                 wb_mark,
    output logic [SS-1:0][ID_W-1:0]       wb_mark_id,

    // retirement
    input  wire logic [SS-1:0]            head_done,
    output logic                          retire,
    output logic [ID_W-1:0]               head,
    output logic [SS-1:0][63:0]           commit_order,
    output logic                          commit_valid
);

    localparam logic [CNT_W-1:0] GROUP = CNT_W'(SS);
    localparam logic [CNT_W-1:0] MAX_FILL = CNT_W'(ROB_DEPTH - SS);
    localparam logic [ID_W-1:0] STEP = ID_W'(SS);

    // occupied entries, always a multiple of SS
    logic [CNT_W-1:0] count;
    logic [63:0]      order_cnt;

    // room for one more full group
    assign disp_ready = (count <= MAX_FILL);
    assign push = disp_valid && disp_ready;

    // oldest group retires only when every slot has completed
    assign retire = (count != '0) && (&head_done);
    assign commit_valid = retire;

    genvar g;
    generate
        for (g = 0; g < SS; g++) begin : g_slot
            logic [ID_W-1:0] wb_offset;

            // ids are simply the queue slot
            assign disp_rob_id[g] = tail + ID_W'(g);

            // distance from head decides whether the id is live
            assign wb_offset = wb_rob_id[g] - head;
            assign wb_mark[g] = wb_valid[g] && ({1'b0, wb_offset} < count);
            assign wb_mark_id[g] = wb_rob_id[g];

            assign commit_order[g] = order_cnt + 64'(g);
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            order_cnt <= '0;
        end else begin
            if (push) begin
                tail <= tail + STEP;
            end
            if (retire) begin
                head      <= head + STEP;
                order_cnt <= order_cnt + 64'(SS);
            end
            case ({push, retire})
                2'b10:   count <= count + GROUP;
                2'b01:   count <= count - GROUP;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // architectural register file shape
    localparam int ARCH_W = 5;
    localparam int ARCH_REGS = 32;

    // operation class carried by each reorder buffer entry
    typedef enum logic [1:0] {
        op_alu    = 2'd0,
        op_load   = 2'd1,
        op_store  = 2'd2,
        op_branch = 2'd3
    } op_class_t;

    // stores and branches have no destination register
    function automatic logic op_writes_rd(input op_class_t op);
        logic wr;
        case (op)
            op_alu:  wr = 1'b1;
            op_load: wr = 1'b1;
            default: wr = 1'b0;
        endcase
        return wr;
    endfunction

endpackage

`default_nettype wire
